/* files.f */
+incdir+.
tile_feat_pkg.sv
rv_pipe_reg.sv
pixel_xy_counter.sv
linebuf_y_1line.sv
edge_grad.sv
pix_xy_linebuf_top.sv
tb_pix_xy_linebuf.sv

/* Makefile */
# Verilator build and run of the tile feature front end testbench
# a $fatal in the testbench gives a failing exit status

TOP = tb_pix_xy_linebuf

.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

/* tb_pix_xy_linebuf.sv */
// ----------------------------------------------------------
// directed tests on a 16x8 frame, expected records from a tb model
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

module tb_pix_xy_linebuf;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int W          = 16;
  localparam int H          = 8;
  localparam int FRAME      = W * H;
  localparam int TILE       = 1 << `TF_TILE_SHIFT;
  localparam int CLK_PERIOD = 40;
  // test 1 sends one pixel, tests 2 to 4 four frames, test 5 nineteen pixels
  localparam int TOTAL_PIX  = 1 + 4 * FRAME + 19;
  localparam int WD_CYCLES  = TOTAL_PIX * 40 + 500;

  // expected output record
  typedef struct {
    int x;
    int y;
    int tile_j;
    int tile_i;
    int x_mod;
    int y_mod;
    int line_last;
    int frame_last;
    int tile_last;
    int y_cur;
    int y_left;
    int y_up;
    int grad;
  } exp_rec_t;

  logic                    clk;
  logic                    rst;
  logic                    pix_valid;
  logic                    pix_ready;
  logic                    sof;
  logic                    eol;
  logic [`TF_YPIX_W-1:0]   y_in;
  logic                    out_valid;
  logic                    out_ready;
  logic [`TF_X_W-1:0]      x;
  logic [`TF_Y_W-1:0]      y;
  logic [`TF_X_W-1:0]      tile_j;
  logic [`TF_Y_W-1:0]      tile_i;
  logic [1:0]              x_mod;
  logic [1:0]              y_mod;
  logic                    tile_last;
  logic                    line_last;
  logic                    frame_last;
  logic [`TF_YPIX_W-1:0]   y_cur;
  logic [`TF_YPIX_W-1:0]   y_left;
  logic [`TF_YPIX_W-1:0]   y_up;
  logic [`TF_YPIX_W+1:0]   grad;
  logic                    err_sof_midframe;
  logic                    err_eol_mismatch;

  // ----------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------
  exp_rec_t exp_q[$];
  int       mdl_x;
  int       mdl_y;
  int       line_ref [0:W-1];
  int       prev_ref;
  int       exp_err_sof;
  int       exp_err_eol;
  // random out_ready when set
  bit       rand_ready;

  pix_xy_linebuf_top #(
    .ACTIVE_W(W),
    .ACTIVE_H(H)
  ) dut (
    .clk             (clk),
    .rst             (rst),
    .pix_valid       (pix_valid),
    .pix_ready       (pix_ready),
    .sof             (sof),
    .eol             (eol),
    .y_in            (y_in),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .x               (x),
    .y               (y),
    .tile_j          (tile_j),
    .tile_i          (tile_i),
    .x_mod           (x_mod),
    .y_mod           (y_mod),
    .tile_last       (tile_last),
    .line_last       (line_last),
    .frame_last      (frame_last),
    .y_cur           (y_cur),
    .y_left          (y_left),
    .y_up            (y_up),
    .grad            (grad),
    .err_sof_midframe(err_sof_midframe),
    .err_eol_mismatch(err_eol_mismatch)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // sink side, low in reset, then held high or random per edge
  initial begin
    logic [31:0] r;
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      r = $urandom;
      if (rst) begin
        out_ready <= 1'b0;
      end else begin
        out_ready <= rand_ready ? r[0] : 1'b1;
      end
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_record(input exp_rec_t e);
    check_value("x", 32'(x), e.x);
    check_value("y", 32'(y), e.y);
    check_value("tile_j", 32'(tile_j), e.tile_j);
    check_value("tile_i", 32'(tile_i), e.tile_i);
    check_value("x_mod", 32'(x_mod), e.x_mod);
    check_value("y_mod", 32'(y_mod), e.y_mod);
    check_value("line_last", 32'(line_last), e.line_last);
    check_value("frame_last", 32'(frame_last), e.frame_last);
    check_value("tile_last", 32'(tile_last), e.tile_last);
    check_value("y_cur", 32'(y_cur), e.y_cur);
    check_value("y_left", 32'(y_left), e.y_left);
    check_value("y_up", 32'(y_up), e.y_up);
    check_value("grad", 32'(grad), e.grad);
  endtask

  // ----------------------------------------------------------
  // output monitor, in-order against the expected queue
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("an output record appeared with no pixel pending at %0t ns", $time);
        $display("ERRORS FOUND");
        $fatal(1, "unexpected output");
      end else begin
        compare_record(exp_q.pop_front());
      end
    end
  end

  // expected record of one accepted pixel, then raster advance
  task automatic model_accept(input int luma, input bit sof_i, input bit eol_i);
    exp_rec_t e;
    int cx;
    int cy;
    int dl;
    int du;
    cx = sof_i ? 0 : mdl_x;
    cy = sof_i ? 0 : mdl_y;
    if (sof_i && !(mdl_x == 0 && mdl_y == 0)) exp_err_sof = 1;
    if (int'(eol_i) != int'(cx == W - 1)) exp_err_eol = 1;
    e.x          = cx;
    e.y          = cy;
    e.tile_j     = cx / TILE;
    e.tile_i     = cy / TILE;
    e.x_mod      = cx % TILE;
    e.y_mod      = cy % TILE;
    e.line_last  = int'(cx == W - 1);
    e.frame_last = int'(cx == W - 1 && cy == H - 1);
    e.tile_last  = int'(cx % TILE == TILE - 1 && cy % TILE == TILE - 1);
    e.y_cur      = luma;
    // neighbours outside the frame are zero
    e.y_left     = (cx == 0) ? 0 : prev_ref;
    e.y_up       = (cy == 0) ? 0 : line_ref[cx];
    dl = (luma >= e.y_left) ? luma - e.y_left : e.y_left - luma;
    du = (luma >= e.y_up) ? luma - e.y_up : e.y_up - luma;
    e.grad = dl + du;
    exp_q.push_back(e);
    line_ref[cx] = luma;
    prev_ref     = luma;
    if (cx == W - 1) begin
      mdl_x = 0;
      mdl_y = (cy == H - 1) ? 0 : cy + 1;
    end else begin
      mdl_x = cx + 1;
      mdl_y = cy;
    end
  endtask

  // drive one pixel, optional idle gap first, returns at the accept edge
  task automatic send_pixel(input int luma, input bit sof_i, input bit eol_i, input int gap);
    if (gap > 0) begin
      pix_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    pix_valid <= 1'b1;
    sof       <= sof_i;
    eol       <= eol_i;
    y_in      <= 10'(luma);
    @(posedge clk);
    while (!pix_ready) @(posedge clk);
    model_accept(luma, sof_i, eol_i);
  endtask

  task automatic send_frame(input int gap_max);
    logic [31:0] r;
    int gap;
    for (int yy = 0; yy < H; yy++) begin
      for (int xx = 0; xx < W; xx++) begin
        r   = $urandom;
        gap = (gap_max > 0) ? int'(r[15:0]) % (gap_max + 1) : 0;
        send_pixel(int'(r[25:16]), xx == 0 && yy == 0, xx == W - 1, gap);
      end
    end
  endtask

  // stop the input and wait until every record came out
  task automatic wait_drain();
    pix_valid <= 1'b0;
    sof       <= 1'b0;
    eol       <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic check_flags();
    check_value("err_sof_midframe", 32'(err_sof_midframe), exp_err_sof);
    check_value("err_eol_mismatch", 32'(err_eol_mismatch), exp_err_eol);
  endtask

  task automatic apply_reset();
    rst       <= 1'b1;
    pix_valid <= 1'b0;
    sof       <= 1'b0;
    eol       <= 1'b0;
    repeat (16) @(posedge clk);
    rst         <= 1'b0;
    mdl_x       = 0;
    mdl_y       = 0;
    exp_err_sof = 0;
    exp_err_eol = 0;
    // records still in flight are dropped by the reset
    exp_q.delete();
    @(posedge clk);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset_latency();
    check_value("out_valid after reset", 32'(out_valid), 0);
    check_value("pix_ready after reset", 32'(pix_ready), 1);
    check_flags();
    send_pixel(321, 1'b1, 1'b0, 0);
    pix_valid <= 1'b0;
    sof       <= 1'b0;
    // out_valid shows up on the third edge after accept
    for (int k = 1; k <= 3; k++) begin
      @(posedge clk);
      check_value("out_valid latency", 32'(out_valid), (k == 3) ? 1 : 0);
    end
    wait_drain();
    apply_reset();
  endtask

  task automatic test_full_frame();
    rand_ready = 1'b0;
    send_frame(0);
    wait_drain();
    check_flags();
  endtask

  task automatic test_backpressure();
    rand_ready = 1'b1;
    send_frame(3);
    wait_drain();
    rand_ready = 1'b0;
    check_flags();
  endtask

  // second frame starts with y_up forced to zero
  task automatic test_two_frames();
    send_frame(0);
    send_frame(0);
    wait_drain();
    check_flags();
  endtask

  task automatic test_framing_errors();
    for (int i = 0; i < 6; i++) send_pixel(100 + i * 7, i == 0, 1'b0, 0);
    wait_drain();
    check_flags();
    // sof at x 6 restarts at the origin
    send_pixel(512, 1'b1, 1'b0, 0);
    wait_drain();
    check_flags();
    // eol early at x 5
    for (int i = 1; i <= 5; i++) send_pixel(40 * i, 1'b0, i == 5, 0);
    for (int i = 6; i <= 9; i++) send_pixel(900 - i, 1'b0, 1'b0, 1);
    wait_drain();
    check_value("err_sof_midframe set", 32'(err_sof_midframe), 1);
    check_value("err_eol_mismatch set", 32'(err_eol_mismatch), 1);
    check_flags();
    // three pixels still in the pipeline when reset hits
    for (int i = 0; i < 3; i++) send_pixel(7 + i, 1'b0, 1'b0, 0);
    apply_reset();
    check_flags();
    check_value("out_valid after second reset", 32'(out_valid), 0);
  endtask

  // watchdog sized from the pixel count
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout, the DUT stopped moving pixels through the pipeline");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(37383));
    rst        = 1'b1;
    pix_valid  = 1'b0;
    sof        = 1'b0;
    eol        = 1'b0;
    y_in       = '0;
    rand_ready = 1'b0;
    prev_ref   = 0;
    foreach (line_ref[i]) line_ref[i] = 0;
    apply_reset();
    test_reset_latency();
    test_full_frame();
    test_backpressure();
    test_two_frames();
    test_framing_errors();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* pix_xy_linebuf_top.sv */
// ----------------------------------------------------------
// counter -> line buffer -> edge stage, 3 cycle latency
// full rate stream, back-pressure reaches pix_ready
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

module pix_xy_linebuf_top #(
  parameter int unsigned ACTIVE_W = `TF_ACTIVE_W_DEF,
  parameter int unsigned ACTIVE_H = `TF_ACTIVE_H_DEF
) (
  input  logic                    clk,
  input  logic                    rst,
  // pixel stream in
  input  logic                    pix_valid,
  output logic                    pix_ready,
  input  logic                    sof,
  input  logic                    eol,
  input  logic [`TF_YPIX_W-1:0]   y_in,
  // feature stream out
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [`TF_X_W-1:0]      x,
  output logic [`TF_Y_W-1:0]      y,
  output logic [`TF_X_W-1:0]      tile_j,
  output logic [`TF_Y_W-1:0]      tile_i,
  output logic [1:0]              x_mod,
  output logic [1:0]              y_mod,
  output logic                    tile_last,
  output logic                    line_last,
  output logic                    frame_last,
  output logic [`TF_YPIX_W-1:0]   y_cur,
  output logic [`TF_YPIX_W-1:0]   y_left,
  output logic [`TF_YPIX_W-1:0]   y_up,
  output logic [`TF_YPIX_W+1:0]   grad,
  // sticky framing errors
  output logic                    err_sof_midframe,
  output logic                    err_eol_mismatch
);

  import tile_feat_pkg::*;

  // ----------------------------------------------------------
  // stage links
  // ----------------------------------------------------------
  logic                   v1_valid;
  logic                   v1_ready;
  pix_meta_t              v1_meta;

  logic                   v2_valid;
  logic                   v2_ready;
  pix_meta_t              v2_meta;
  logic [`TF_YPIX_W-1:0]  v2_left;
  logic [`TF_YPIX_W-1:0]  v2_up;

  edge_out_t              out_rec;

  // coordinates and framing
  pixel_xy_counter #(
    .ACTIVE_W(ACTIVE_W),
    .ACTIVE_H(ACTIVE_H)
  ) u_xy (
    .clk             (clk),
    .rst             (rst),
    .pix_valid       (pix_valid),
    .pix_ready       (pix_ready),
    .sof             (sof),
    .eol             (eol),
    .y_in            (y_in),
    .v1_valid        (v1_valid),
    .v1_ready        (v1_ready),
    .v1_meta         (v1_meta),
    .err_sof_midframe(err_sof_midframe),
    .err_eol_mismatch(err_eol_mismatch)
  );

  // left and up neighbours
  linebuf_y_1line #(
    .ACTIVE_W(ACTIVE_W)
  ) u_lb (
    .clk     (clk),
    .rst     (rst),
    .v1_valid(v1_valid),
    .v1_ready(v1_ready),
    .v1_meta (v1_meta),
    .v2_valid(v2_valid),
    .v2_ready(v2_ready),
    .v2_meta (v2_meta),
    .y_left  (v2_left),
    .y_up    (v2_up)
  );

  // gradient and record packing
  edge_grad u_edge (
    .clk      (clk),
    .rst      (rst),
    .v2_valid (v2_valid),
    .v2_ready (v2_ready),
    .v2_meta  (v2_meta),
    .y_left   (v2_left),
    .y_up     (v2_up),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_rec  (out_rec)
  );

  // ----------------------------------------------------------
  // unpack output record
  // ----------------------------------------------------------
  assign x          = out_rec.x;
  assign y          = out_rec.y;
  assign tile_j     = out_rec.tile_j;
  assign tile_i     = out_rec.tile_i;
  assign x_mod      = out_rec.x_mod;
  assign y_mod      = out_rec.y_mod;
  assign tile_last  = out_rec.tile_last;
  assign line_last  = out_rec.line_last;
  assign frame_last = out_rec.frame_last;
  assign y_cur      = out_rec.y_cur;
  assign y_left     = out_rec.y_left;
  assign y_up       = out_rec.y_up;
  assign grad       = out_rec.grad;

endmodule

/* edge_grad.sv */
// ----------------------------------------------------------
// grad = |cur-left| + |cur-up|, unsaturated, one cycle latency
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

module edge_grad (
  input  logic                     clk,
  input  logic                     rst,
  // pixel with neighbours in
  input  logic                     v2_valid,
  output logic                     v2_ready,
  input  tile_feat_pkg::pix_meta_t v2_meta,
  input  logic [`TF_YPIX_W-1:0]    y_left,
  input  logic [`TF_YPIX_W-1:0]    y_up,
  // output record
  output logic                     out_valid,
  input  logic                     out_ready,
  output tile_feat_pkg::edge_out_t out_rec
);

  import tile_feat_pkg::*;

  localparam int PW = `TF_YPIX_W;

  logic [PW-1:0] d_left;
  logic [PW-1:0] d_up;
  edge_out_t     rec_d;

  // absolute differences against each neighbour
  assign d_left = (v2_meta.luma >= y_left) ? v2_meta.luma - y_left : y_left - v2_meta.luma;
  assign d_up   = (v2_meta.luma >= y_up) ? v2_meta.luma - y_up : y_up - v2_meta.luma;

  // pack record, coordinates pass straight through
  always_comb begin
    rec_d            = '0;
    rec_d.x          = v2_meta.x;
    rec_d.y          = v2_meta.y;
    rec_d.tile_j     = v2_meta.tile_j;
    rec_d.tile_i     = v2_meta.tile_i;
    rec_d.x_mod      = v2_meta.x_mod;
    rec_d.y_mod      = v2_meta.y_mod;
    rec_d.line_last  = v2_meta.line_last;
    rec_d.frame_last = v2_meta.frame_last;
    rec_d.tile_last  = v2_meta.tile_last;
    rec_d.y_cur      = v2_meta.luma;
    rec_d.y_left     = y_left;
    rec_d.y_up       = y_up;
    // two extra bits, sum cannot overflow
    rec_d.grad       = {2'b00, d_left} + {2'b00, d_up};
  end

  rv_pipe_reg #(
    .payload_t(edge_out_t)
  ) u_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (v2_valid),
    .in_ready (v2_ready),
    .in_data  (rec_d),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_rec)
  );

endmodule

/* linebuf_y_1line.sv */
// ----------------------------------------------------------
// one line of luma, gives left and up neighbours, one cycle latency
// neighbours outside the frame read as zero; ACTIVE_W must be >= 2
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

module linebuf_y_1line #(
  parameter int unsigned ACTIVE_W = `TF_ACTIVE_W_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  // tagged pixel in
  input  logic                     v1_valid,
  output logic                     v1_ready,
  input  tile_feat_pkg::pix_meta_t v1_meta,
  // pixel with neighbours out
  output logic                     v2_valid,
  input  logic                     v2_ready,
  output tile_feat_pkg::pix_meta_t v2_meta,
  output logic [`TF_YPIX_W-1:0]    y_left,
  output logic [`TF_YPIX_W-1:0]    y_up
);

  import tile_feat_pkg::*;

  localparam int AW = $clog2(ACTIVE_W);
  localparam int PW = `TF_YPIX_W;

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  // previous line, indexed by x
  logic [PW-1:0] line_mem [0:ACTIVE_W-1];
  // last accepted luma
  logic [PW-1:0] prev_q;

  logic          valid_q;
  pix_meta_t     meta_q;
  logic [PW-1:0] left_q;
  logic [PW-1:0] up_q;

  logic          accept;
  logic [AW-1:0] addr;

  // same ready rule as the other slices
  assign v1_ready = !valid_q || v2_ready;
  assign accept   = v1_valid && v1_ready;
  assign addr     = v1_meta.x[AW-1:0];

  // output occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (v2_ready) begin
      valid_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // read before write on accept
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      meta_q <= v1_meta;
      // old content at x is the pixel above
      up_q   <= (v1_meta.y == '0) ? '0 : line_mem[addr];
      // first column has no left neighbour
      left_q <= (v1_meta.x == '0) ? '0 : prev_q;
      line_mem[addr] <= v1_meta.luma;
      prev_q <= v1_meta.luma;
    end
  end

  assign v2_valid = valid_q;
  assign v2_meta  = meta_q;
  assign y_left   = left_q;
  assign y_up     = up_q;

endmodule

/* pixel_xy_counter.sv */
// ----------------------------------------------------------
// x/y and 4x4 tile tagging of accepted pixels, one cycle latency
// sof restarts at (0,0); error flags are sticky until reset
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

module pixel_xy_counter #(
  parameter int unsigned ACTIVE_W = `TF_ACTIVE_W_DEF,
  parameter int unsigned ACTIVE_H = `TF_ACTIVE_H_DEF
) (
  input  logic                    clk,
  input  logic                    rst,
  // pixel stream in
  input  logic                    pix_valid,
  output logic                    pix_ready,
  input  logic                    sof,
  input  logic                    eol,
  input  logic [`TF_YPIX_W-1:0]   y_in,
  // tagged pixel out
  output logic                    v1_valid,
  input  logic                    v1_ready,
  output tile_feat_pkg::pix_meta_t v1_meta,
  // framing checks
  output logic                    err_sof_midframe,
  output logic                    err_eol_mismatch
);

  import tile_feat_pkg::*;

  localparam int XW = `TF_X_W;
  localparam int YW = `TF_Y_W;
  localparam int TS = `TF_TILE_SHIFT;

  localparam logic [XW-1:0] X_LAST = XW'(ACTIVE_W - 1);
  localparam logic [YW-1:0] Y_LAST = YW'(ACTIVE_H - 1);

  // ----------------------------------------------------------
  // position state
  // ----------------------------------------------------------
  logic [XW-1:0] x_q;
  logic [YW-1:0] y_q;

  // position of the pixel on the input this cycle
  logic [XW-1:0] cur_x;
  logic [YW-1:0] cur_y;
  logic          at_origin;
  logic          accept;
  logic          x_at_last;
  logic          y_at_last;

  pix_meta_t     meta_d;

  assign accept    = pix_valid && pix_ready;
  assign at_origin = (x_q == '0) && (y_q == '0);

  // sof pins this pixel to the origin
  assign cur_x = sof ? '0 : x_q;
  assign cur_y = sof ? '0 : y_q;

  assign x_at_last = (cur_x == X_LAST);
  assign y_at_last = (cur_y == Y_LAST);

  // ----------------------------------------------------------
  // tag fields
  // ----------------------------------------------------------
  always_comb begin
    meta_d            = '0;
    meta_d.x          = cur_x;
    meta_d.y          = cur_y;
    meta_d.luma       = y_in;
    meta_d.tile_j     = cur_x >> TS;
    meta_d.tile_i     = cur_y >> TS;
    // position inside the tile
    meta_d.x_mod      = cur_x[TS-1:0];
    meta_d.y_mod      = cur_y[TS-1:0];
    meta_d.line_last  = x_at_last;
    meta_d.frame_last = x_at_last && y_at_last;
    // bottom right corner of a tile
    meta_d.tile_last  = (cur_x[TS-1:0] == 2'd3) && (cur_y[TS-1:0] == 2'd3);
  end

  // advance raster position on accept
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else if (accept) begin
      if (x_at_last) begin
        x_q <= '0;
        // wrap at frame end
        y_q <= y_at_last ? '0 : cur_y + 1'b1;
      end else begin
        x_q <= cur_x + 1'b1;
        y_q <= cur_y;
      end
    end
  end

  // ----------------------------------------------------------
  // sticky framing errors
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      err_sof_midframe <= 1'b0;
      err_eol_mismatch <= 1'b0;
    end else if (accept) begin
      // sof anywhere but the origin
      if (sof && !at_origin) begin
        err_sof_midframe <= 1'b1;
      end
      // eol must mark exactly the last column
      if (eol != x_at_last) begin
        err_eol_mismatch <= 1'b1;
      end
    end
  end

  // output slice, gives the one cycle latency
  rv_pipe_reg #(
    .payload_t(pix_meta_t)
  ) u_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (pix_valid),
    .in_ready (pix_ready),
    .in_data  (meta_d),
    .out_valid(v1_valid),
    .out_ready(v1_ready),
    .out_data (v1_meta)
  );

endmodule

/* rv_pipe_reg.sv */
// ----------------------------------------------------------
// one-entry ready/valid slice, full rate when drained each cycle
// in_ready is combinational from out_ready
// ----------------------------------------------------------
module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  // upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  // accept when empty or the entry leaves this cycle
  assign in_ready = !valid_q || out_ready;

  // occupancy flag
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      valid_q <= 1'b1;
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  // payload, loaded only on an input transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

endmodule

/* tile_feat_pkg.sv */
// ----------------------------------------------------------
// payload records passed between the pipeline stages
// ----------------------------------------------------------
`include "tile_feat_defs.svh"

package tile_feat_pkg;

  // one accepted pixel tagged with its position
  typedef struct packed {
    logic [`TF_X_W-1:0]    x;
    logic [`TF_Y_W-1:0]    y;
    logic [`TF_YPIX_W-1:0] luma;
    logic [`TF_X_W-1:0]    tile_j;
    logic [`TF_Y_W-1:0]    tile_i;
    logic [1:0]            x_mod;
    logic [1:0]            y_mod;
    logic                  line_last;
    logic                  frame_last;
    logic                  tile_last;
  } pix_meta_t;

  // final record with neighbours and gradient
  typedef struct packed {
    logic [`TF_X_W-1:0]      x;
    logic [`TF_Y_W-1:0]      y;
    logic [`TF_X_W-1:0]      tile_j;
    logic [`TF_Y_W-1:0]      tile_i;
    logic [1:0]              x_mod;
    logic [1:0]              y_mod;
    logic                    line_last;
    logic                    frame_last;
    logic                    tile_last;
    logic [`TF_YPIX_W-1:0]   y_cur;
    logic [`TF_YPIX_W-1:0]   y_left;
    logic [`TF_YPIX_W-1:0]   y_up;
    logic [`TF_YPIX_W+1:0]   grad;
  } edge_out_t;

endpackage

/* tile_feat_defs.svh */
// ----------------------------------------------------------
// widths and frame defaults shared by the tile feature front end
// tile edge is 1 << TF_TILE_SHIFT, mod fields assume a shift of 2
// ----------------------------------------------------------
`ifndef TILE_FEAT_DEFS_SVH
`define TILE_FEAT_DEFS_SVH

// ----------------------------------------------------------
// coordinate widths
// ----------------------------------------------------------
// x and tile_j, enough for 2047 columns
`define TF_X_W 11
// y and tile_i, enough for 1023 lines
`define TF_Y_W 10

// luma sample width
`define TF_YPIX_W 10

// log2 of the tile edge, 4x4 tiles
`define TF_TILE_SHIFT 2

// ----------------------------------------------------------
// default active frame size
// ----------------------------------------------------------
`define TF_ACTIVE_W_DEF 1280
`define TF_ACTIVE_H_DEF 720

`endif
